// File: project.f
hw/masked_pkg.sv
hw/masked_and.sv
hw/masked_full_adder.sv
hw/masked_boolean_adder.sv
hw/share_splitter.sv
hw/rnd_lfsr.sv
hw/masked_a2b.sv
verification/masked_a2b_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module masked_a2b_tb -f project.f -o sim_a2b \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_a2b 2>&1)
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// File: verification/masked_a2b_tb.sv
// Self-checking A2B testbench; assumes ADD_WIDTH even and A2B_LATENCY >= 2, stops at first error
module masked_a2b_tb
    import masked_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ========================================
    // Run sizing
    // ========================================

    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned NUM_RANDOM   = 500;    // Random slots with about one in five idle
    localparam int unsigned NUM_DIRECTED = 8;      // Carry chain corner pairs
    localparam int unsigned ZERO_PRE     = 24;     // Fills the pipeline before zeroize rises
    localparam int unsigned ZERO_CYCLES  = 3;
    localparam int unsigned ZERO_POST    = 10;
    localparam int unsigned NUM_FRESH    = 32;     // Same secret, repeated
    localparam int unsigned NUM_RESEED   = 40;
    localparam int unsigned NUM_PHASES   = 6;
    localparam int unsigned TOTAL_ITEMS  = NUM_RANDOM + NUM_DIRECTED + ZERO_PRE + ZERO_CYCLES
                                         + ZERO_POST + NUM_FRESH + NUM_RESEED;
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_ITEMS + A2B_LATENCY * NUM_PHASES + 100;

    // Edge patterns for the adder
    localparam logic [ADD_WIDTH-1:0] ALL_ONES = '1;
    localparam logic [ADD_WIDTH-1:0] ONE      = {{(ADD_WIDTH-1){1'b0}}, 1'b1};
    localparam logic [ADD_WIDTH-1:0] MSB_ONLY = {1'b1, {(ADD_WIDTH-1){1'b0}}};
    localparam logic [ADD_WIDTH-1:0] ALT_10   = {(ADD_WIDTH/2){2'b10}};
    localparam logic [ADD_WIDTH-1:0] ALT_01   = {(ADD_WIDTH/2){2'b01}};

    // DUT ports
    logic                 clk;
    logic                 rst_n;
    logic                 zeroize;
    logic                 in_valid;
    logic [ADD_WIDTH-1:0] a0;
    logic [ADD_WIDTH-1:0] a1;
    logic                 seed_load;
    logic [RND_WIDTH-1:0] seed;
    logic [ADD_WIDTH-1:0] b0;
    logic [ADD_WIDTH-1:0] b1;
    logic                 out_valid;

    // Reference pipeline with one slot per cycle of latency
    logic [A2B_LATENCY-1:0]                exp_valid_pipe;
    logic [A2B_LATENCY-1:0][ADD_WIDTH-1:0] exp_sum_pipe;
    logic [ADD_WIDTH-1:0]                  in_sum;        // Secret sum wrapping mod 2^ADD_WIDTH

    logic                 checks_on;                      // Off until reset has reached the DUT
    logic                 fresh_window;                   // Collect b0 during freshness phase
    logic [ADD_WIDTH-1:0] fresh_first;
    logic                 fresh_changed;
    int unsigned          fresh_seen;

    masked_a2b UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .a0        (a0),
        .a1        (a1),
        .seed_load (seed_load),
        .seed      (seed),
        .b0        (b0),
        .b1        (b1),
        .out_valid (out_valid)
    );

    always #2 clk = ~clk;                                 // 4 ns period

    // ========================================
    // Reference model
    // ========================================

    assign in_sum = a0 + a1;

    // Item taken on an edge shows up A2B_LATENCY edges later and zeroize drops all
    always @(posedge clk) begin
        if (!rst_n || zeroize) begin
            exp_valid_pipe <= '0;
            exp_sum_pipe   <= '0;
        end else begin
            exp_valid_pipe <= {exp_valid_pipe[A2B_LATENCY-2:0], in_valid};
            exp_sum_pipe   <= {exp_sum_pipe[A2B_LATENCY-2:0], in_sum};
        end
    end

    // Watch b0 during the repeated-secret phase
    always @(posedge clk) begin
        if (fresh_window && out_valid) begin
            if (fresh_seen == 0)
                fresh_first <= b0;                        // Reference share value
            else if (b0 != fresh_first)
                fresh_changed <= 1'b1;
            fresh_seen <= fresh_seen + 1;
        end
    end

    // ========================================
    // Checks
    // ========================================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first failing check");
    endtask

    valid_timing_check: assert property (@(posedge clk) disable iff (!checks_on)
            out_valid == exp_valid_pipe[A2B_LATENCY-1])
        else report_failure($sformatf("Mismatch at %0t ns: out_valid expected %0b got %0b",
            $time, $sampled(exp_valid_pipe[A2B_LATENCY-1]), $sampled(out_valid)));

    sum_check: assert property (@(posedge clk) disable iff (!checks_on)
            out_valid |-> ((b0 ^ b1) == exp_sum_pipe[A2B_LATENCY-1]))
        else report_failure($sformatf("Mismatch at %0t ns: b0^b1 expected %h got %h",
            $time, $sampled(exp_sum_pipe[A2B_LATENCY-1]), $sampled(b0 ^ b1)));

    // No stale share may leave while nothing is valid
    quiet_check: assert property (@(posedge clk) disable iff (!checks_on)
            !out_valid |-> (b0 == '0 && b1 == '0))
        else report_failure($sformatf("Mismatch at %0t ns: b0 b1 expected 0 0 got %h %h",
            $time, $sampled(b0), $sampled(b1)));

    reset_check: assert property (@(posedge clk) disable iff (!checks_on)
            $past(!rst_n) |-> !out_valid)
        else report_failure("Reset did not hold out_valid low");

    zeroize_check: assert property (@(posedge clk) disable iff (!checks_on)
            $past(zeroize) |-> !out_valid)
        else report_failure("Zeroize did not clear out_valid");

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic logic [ADD_WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $urandom;
        return r[ADD_WIDTH-1:0];
    endfunction

    task automatic issue_item(input logic [ADD_WIDTH-1:0] x0, input logic [ADD_WIDTH-1:0] x1);
        @(posedge clk);
        in_valid  <= 1'b1;
        a0        <= x0;
        a1        <= x1;
        seed_load <= 1'b0;                                // Reseed is a single-cycle pulse
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid  <= 1'b0;
        a0        <= rand_word();                         // Junk must not surface
        a1        <= rand_word();
        seed_load <= 1'b0;
    endtask

    // Stop issuing and wait until the model holds nothing in flight
    task automatic drain_pipeline();
        @(posedge clk);
        in_valid  <= 1'b0;
        seed_load <= 1'b0;
        do
            @(posedge clk);
        while (exp_valid_pipe != '0);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        logic [ADD_WIDTH-1:0] fresh_a0;
        logic [ADD_WIDTH-1:0] fresh_a1;
        clk           = 1'b0;
        rst_n         = 1'b0;
        zeroize       = 1'b0;
        in_valid      = 1'b0;
        a0            = '0;
        a1            = '0;
        seed_load     = 1'b0;
        seed          = '0;
        checks_on     = 1'b0;
        fresh_window  = 1'b0;
        fresh_first   = '0;
        fresh_changed = 1'b0;
        fresh_seen    = 0;
        void'($urandom(32'h6dd4));

        // Outputs must stay quiet throughout reset
        @(posedge clk);
        checks_on <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) idle_cycle();

        // Back-to-back random load with random gaps
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if ($urandom_range(9) < 8)
                issue_item(rand_word(), rand_word());
            else
                idle_cycle();
        end
        drain_pipeline();

        // Carry chain edges
        issue_item(ALL_ONES, ONE);                        // Carry runs the full width
        issue_item(ONE, ALL_ONES);
        issue_item(ALL_ONES, ALL_ONES);
        issue_item('0, '0);
        issue_item(ALT_10, ALT_01);                       // No carries at all
        issue_item(ALT_10, ALT_10);
        issue_item(ALT_01, ALT_01);
        issue_item(MSB_ONLY, MSB_ONLY);                   // Top carry dropped
        drain_pipeline();

        // Zeroize over a full pipeline so items issued under zeroize are lost too
        for (int i = 0; i < ZERO_PRE; i++)
            issue_item(rand_word(), rand_word());
        for (int i = 0; i < ZERO_CYCLES; i++) begin
            issue_item(rand_word(), rand_word());
            zeroize <= 1'b1;
        end
        for (int i = 0; i < ZERO_POST; i++) begin
            issue_item(rand_word(), rand_word());
            zeroize <= 1'b0;
        end
        drain_pipeline();

        // Same secret repeated so the shares must differ
        fresh_a0 = rand_word();
        fresh_a1 = rand_word();
        fresh_window <= 1'b1;
        for (int i = 0; i < NUM_FRESH; i++)
            issue_item(fresh_a0, fresh_a1);
        drain_pipeline();
        fresh_window <= 1'b0;
        assert (fresh_seen == NUM_FRESH)
            else report_failure($sformatf(
                "Mismatch at %0t ns: fresh result count expected %0d got %0d",
                $time, NUM_FRESH, fresh_seen));
        assert (fresh_changed)
            else report_failure("Masking freshness failed, b0 kept one value for a repeated secret");

        // Reseed mid-stream once with a random seed and once with zero
        for (int i = 0; i < NUM_RESEED; i++) begin
            issue_item(rand_word(), rand_word());
            if (i == 10) begin
                seed_load <= 1'b1;
                seed      <= $urandom;
            end else if (i == 25) begin
                seed_load <= 1'b1;
                seed      <= '0;                          // Must fall back to the default
            end
        end
        drain_pipeline();

        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog sized from the item count and per-phase drains
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

endmodule : masked_a2b_tb

// File: hw/masked_a2b.sv
// First-order A2B top; no back-pressure, b0/b1 read as zero and carry no item while out_valid is low
module masked_a2b
    import masked_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,       // Synchronous, active low
    input  logic                 zeroize,     // Level, drops every item in flight
    input  logic                 in_valid,    // a0 and a1 taken this cycle
    input  logic [ADD_WIDTH-1:0] a0,          // Arithmetic share 0
    input  logic [ADD_WIDTH-1:0] a1,          // Arithmetic share 1
    input  logic                 seed_load,   // Reseed pulse for the LFSR
    input  logic [RND_WIDTH-1:0] seed,
    output logic [ADD_WIDTH-1:0] b0,          // Boolean share 0
    output logic [ADD_WIDTH-1:0] b1,          // Boolean share 1
    output logic                 out_valid    // A2B_LATENCY cycles after in_valid
);

    logic [RND_WIDTH-1:0]        rnd;         // Fresh bits, split between the two stages
    logic [ADD_WIDTH-1:0][1:0]   x;           // Masked operand from a0
    logic [ADD_WIDTH-1:0][1:0]   y;           // Masked operand from a1
    logic [ADD_WIDTH-1:0][1:0]   s;           // Shared sum from the adder
    logic [A2B_LATENCY-1:0]      valid_pipe;  // One bit per pipeline stage

    // ========================================
    // Datapath
    // ========================================

    rnd_lfsr u_rnd (
        .clk       (clk),
        .rst_n     (rst_n),
        .seed_load (seed_load),
        .seed      (seed),
        .rnd       (rnd)
    );

    share_splitter u_split (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .a0      (a0),
        .a1      (a1),
        .mask    (rnd[ADD_WIDTH-1:0]),           // Low half masks the operands
        .x       (x),
        .y       (y)
    );

    masked_boolean_adder #(
        .WIDTH (ADD_WIDTH)
    ) u_adder (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (x),
        .y       (y),
        .rnd     (rnd[RND_WIDTH-1:ADD_WIDTH]),   // High half feeds the AND gadgets
        .s       (s)
    );

    // ========================================
    // Valid tracking and output gating
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            valid_pipe <= '0;                    // Flushed items never surface
        end else begin
            valid_pipe <= {valid_pipe[A2B_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[A2B_LATENCY-1];

    // Unpack share pairs, stale shares are held at zero
    always_comb begin
        for (int i = 0; i < ADD_WIDTH; i++) begin
            b0[i] = out_valid & s[i][0];
            b1[i] = out_valid & s[i][1];
        end
    end

endmodule : masked_a2b

// File: hw/rnd_lfsr.sv
// Reseedable Galois LFSR, functional stand-in and not a certified RNG; zeroize does not touch it
module rnd_lfsr
    import masked_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,       // Loads LFSR_DEFAULT_SEED
    input  logic                 seed_load,   // One-cycle pulse, wins over stepping
    input  logic [RND_WIDTH-1:0] seed,        // Zero is replaced by the default seed
    output logic [RND_WIDTH-1:0] rnd          // Whole state, new value every cycle
);

    logic [RND_WIDTH-1:0] state;
    logic [RND_WIDTH-1:0] state_step;       // One Galois step ahead
    logic [RND_WIDTH-1:0] seed_safe;        // seed with the lock-up value filtered

    // ========================================
    // Next-state logic
    // ========================================

    // Right shift, fold taps back in when a one falls out
    assign state_step = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);

    // All-zero state never leaves zero
    assign seed_safe = (seed == '0) ? LFSR_DEFAULT_SEED : seed;

    // ========================================
    // State register
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LFSR_DEFAULT_SEED;
        end else if (seed_load) begin
            state <= seed_safe;             // Reseed, no step this cycle
        end else begin
            state <= state_step;
        end
    end

    assign rnd = state;

endmodule : rnd_lfsr

// File: hw/share_splitter.sv
// Arithmetic shares to masked Boolean operands in one cycle; mask must be fresh for every item
module share_splitter
    import masked_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,      // Synchronous, active low
    input  logic                      zeroize,    // Clears both operand registers
    input  logic [ADD_WIDTH-1:0]      a0,         // Arithmetic share 0
    input  logic [ADD_WIDTH-1:0]      a1,         // Arithmetic share 1
    input  logic [ADD_WIDTH-1:0]      mask,       // Fresh Boolean mask
    output logic [ADD_WIDTH-1:0][1:0] x,          // a0 as Boolean share pairs
    output logic [ADD_WIDTH-1:0][1:0] y           // a1 as Boolean share pairs
);

    // ========================================
    // Mask derivation
    // ========================================

    // Rotate right by one so x and y never carry the same mask bit per position
    logic [ADD_WIDTH-1:0] mask_rot;

    assign mask_rot = {mask[0], mask[ADD_WIDTH-1:1]};

    // ========================================
    // Registered operands
    // ========================================

    // Registering here keeps a0 and a1 from meeting in any later cone unmasked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (zeroize) begin
            x <= '0;
            y <= '0;
        end else begin
            for (int i = 0; i < ADD_WIDTH; i++) begin
                // Share 0 is the masked bit, share 1 the mask itself
                x[i][0] <= a0[i] ^ mask[i];
                x[i][1] <= mask[i];
                y[i][0] <= a1[i] ^ mask_rot[i];
                y[i][1] <= mask_rot[i];
            end
        end
    end

endmodule : share_splitter

// File: hw/masked_boolean_adder.sv
// Pipelined masked ripple-carry adder; WIDTH >= 2, WIDTH + 2 cycles latency, rnd fresh every cycle
module masked_boolean_adder
    import masked_pkg::*;
#(
    parameter int unsigned WIDTH = ADD_WIDTH      // Any width of 2 or more
) (
    input  logic                   clk,
    input  logic                   rst_n,         // Synchronous, active low
    input  logic                   zeroize,       // Drops everything in flight
    input  logic [WIDTH-1:0][1:0]  x,             // Operand, one share pair per bit
    input  logic [WIDTH-1:0][1:0]  y,             // Operand, one share pair per bit
    input  logic [WIDTH-1:0]       rnd,           // Bit i goes to full adder i
    output logic [WIDTH-1:0][1:0]  s              // Boolean-shared sum, all bits aligned
);

    // ========================================
    // Shared ripple signals
    // ========================================

    // carry[i] enters bit i, carry[0] is the constant zero pair
    logic [WIDTH-1:0][1:0] carry;
    // sum[i] leaves bit i, i + 2 cycles after the operands arrive
    logic [WIDTH-1:0][1:0] sum;

    assign carry[0] = 2'b00;

    // Bit i timing, counted from the edge after x and y are presented
    //   skew out   : after i + 1 edges
    //   sum, carry : after i + 2 edges, carry meets bit i + 1 skew output
    //   deskew out : after WIDTH + 2 edges for every bit

    for (genvar i = 0; i < WIDTH; i++) begin : gen_bit

        // ========================================
        // Input skew, i + 1 stages deep
        // ========================================

        logic [i:0][1:0] x_dly;                    // x_dly[i] feeds the bit logic
        logic [i:0][1:0] y_dly;

        always_ff @(posedge clk) begin
            if (!rst_n || zeroize) begin
                x_dly <= '0;
                y_dly <= '0;
            end else begin
                x_dly[0] <= x[i];                  // First stage takes the port
                y_dly[0] <= y[i];
                for (int k = 1; k <= i; k++) begin
                    x_dly[k] <= x_dly[k-1];        // Shift toward the adder
                    y_dly[k] <= y_dly[k-1];
                end
            end
        end

        // ========================================
        // Bit logic
        // ========================================

        if (i < WIDTH - 1) begin : gen_fa
            // Full adder fires one cycle after its skewed operands land
            masked_full_adder u_fa (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .x       (x_dly[i]),
                .y       (y_dly[i]),
                .c_in    (carry[i]),
                .rnd     (rnd[i]),
                .s       (sum[i]),
                .c_out   (carry[i+1])             // Ready just as bit i + 1 sees its operands
            );
        end else begin : gen_top
            // Carry out of the MSB is discarded, so the top bit is linear only
            logic [1:0] top_sum;

            always_ff @(posedge clk) begin
                if (!rst_n || zeroize) begin
                    top_sum <= 2'b00;
                end else begin
                    // Spare random bit refreshes the pair, value unchanged
                    top_sum <= x_dly[i] ^ y_dly[i] ^ carry[i] ^ {2{rnd[i]}};
                end
            end

            assign sum[i] = top_sum;               // Same i + 2 timing as a full adder
        end

        // ========================================
        // Output deskew, WIDTH - i stages deep
        // ========================================

        logic [WIDTH-1-i:0][1:0] s_dly;            // Low bits wait longest

        always_ff @(posedge clk) begin
            if (!rst_n || zeroize) begin
                s_dly <= '0;
            end else begin
                s_dly[0] <= sum[i];
                for (int k = 1; k <= WIDTH - 1 - i; k++) begin
                    s_dly[k] <= s_dly[k-1];
                end
            end
        end

        assign s[i] = s_dly[WIDTH-1-i];            // All bits leave on the same edge
    end

endmodule : masked_boolean_adder

// File: hw/masked_full_adder.sv
// Two-share full adder with one cycle latency; c_out is valid one cycle after x, y and c_in
module masked_full_adder (
    input  logic       clk,
    input  logic       rst_n,        // Synchronous, active low
    input  logic       zeroize,      // Clears sum, delayed carry and gadget state
    input  logic [1:0] x,            // Operand bit, share pair
    input  logic [1:0] y,            // Operand bit, share pair
    input  logic [1:0] c_in,         // Incoming carry, share pair
    input  logic       rnd,          // Fresh bit for the AND gadget
    output logic [1:0] s,            // Registered sum share pair
    output logic [1:0] c_out         // Carry share pair, aligned with s
);

    // ========================================
    // Carry path
    // ========================================

    // maj(x, y, c) = ((x ^ c) & (y ^ c)) ^ c, so one nonlinear gadget suffices
    logic [1:0] and_a;               // x ^ c_in, share-wise
    logic [1:0] and_b;               // y ^ c_in, share-wise
    logic [1:0] and_q;               // Gadget result, one cycle later
    logic [1:0] c_in_d;              // c_in held to line up with and_q

    assign and_a = x ^ c_in;         // Linear, so XOR per share is safe
    assign and_b = y ^ c_in;

    masked_and u_carry_and (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .a       (and_a),
        .b       (and_b),
        .rnd     (rnd),
        .q       (and_q)
    );

    assign c_out = and_q ^ c_in_d;   // Only XOR of registers, no glitchy logic cone

    // ========================================
    // Sum path and carry delay
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s      <= 2'b00;
            c_in_d <= 2'b00;
        end else if (zeroize) begin
            s      <= 2'b00;
            c_in_d <= 2'b00;
        end else begin
            // Sum is linear in the shares
            s      <= x ^ y ^ c_in;
            c_in_d <= c_in;          // Matches the gadget register stage
        end
    end

endmodule : masked_full_adder

// File: hw/masked_and.sv
// First-order DOM AND gadget; rnd must be fresh each cycle and q lags a and b by exactly one cycle
module masked_and (
    input  logic       clk,
    input  logic       rst_n,        // Synchronous, active low
    input  logic       zeroize,      // Clears the gadget registers
    input  logic [1:0] a,            // Share pair, value is a[0] ^ a[1]
    input  logic [1:0] b,            // Share pair, value is b[0] ^ b[1]
    input  logic       rnd,          // Fresh remask bit
    output logic [1:0] q             // Share pair of a & b
);

    // Per-domain products, formed before the register
    logic inner_0;                   // Domain 0 only
    logic inner_1;                   // Domain 1 only
    logic cross_01;                  // Mixes domains, so it gets remasked
    logic cross_10;

    // Register stage acting as the glitch barrier
    logic inner_0_q;
    logic inner_1_q;
    logic cross_01_q;
    logic cross_10_q;

    assign inner_0  = a[0] & b[0];
    assign inner_1  = a[1] & b[1];
    assign cross_01 = (a[0] & b[1]) ^ rnd;   // Same rnd on both cross terms
    assign cross_10 = (a[1] & b[0]) ^ rnd;   // so it cancels in q[0] ^ q[1]

    // Inner terms are registered with the cross terms, all four from one cycle
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            inner_0_q  <= 1'b0;
            inner_1_q  <= 1'b0;
            cross_01_q <= 1'b0;
            cross_10_q <= 1'b0;
        end else begin
            inner_0_q  <= inner_0;
            inner_1_q  <= inner_1;
            cross_01_q <= cross_01;
            cross_10_q <= cross_10;
        end
    end

    // Each output share stays in its own domain plus one refreshed cross term
    assign q[0] = inner_0_q ^ cross_01_q;
    assign q[1] = inner_1_q ^ cross_10_q;

endmodule : masked_and

// File: hw/masked_pkg.sv
// Widths and LFSR constants; RND_WIDTH must stay 32 to match the LFSR polynomial and seed port
package masked_pkg;

    // ========================================
    // Datapath sizing
    // ========================================

    localparam int unsigned ADD_WIDTH = 16;                 // Secret word width, mod 2^ADD_WIDTH

    // ========================================
    // Pipeline latencies, in clock cycles
    // ========================================

    localparam int unsigned SPLIT_LATENCY = 1;              // Registered share split
    localparam int unsigned ADDER_LATENCY = ADD_WIDTH + 2;  // Input skew + ripple + deskew
    // in_valid sample edge up to out_valid
    localparam int unsigned A2B_LATENCY   = SPLIT_LATENCY + ADDER_LATENCY;

    // ========================================
    // Randomness source
    // ========================================

    // Low half masks the splitter, high half feeds the adder gadgets
    localparam int unsigned RND_WIDTH = 2 * ADD_WIDTH;

    // Galois right-shift form of x^32 + x^22 + x^2 + x + 1
    localparam logic [RND_WIDTH-1:0] LFSR_TAPS = 32'h8020_0003;

    // Any nonzero word works, zero would lock the LFSR
    localparam logic [RND_WIDTH-1:0] LFSR_DEFAULT_SEED = 32'h1ace_b00c;

endpackage : masked_pkg
